// ==== build.f ====
+incdir+.
fpu_pkg.sv
fpu_noncomp_fmt_slice.sv
fpu_rr_arbiter.sv
fpu_opgroup_block.sv
fpu_noncomp_top.sv
tb_fpu_noncomp.sv

// ==== Bender.yml ====
package:
  name: fpu_noncomp

sources:
  - files:
      - fpu_pkg.sv
      - fpu_noncomp_fmt_slice.sv
      - fpu_rr_arbiter.sv
      - fpu_opgroup_block.sv
      - fpu_noncomp_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_fpu_noncomp.sv

// ==== tb_fpu_ref.svh ====
`ifndef TB_FPU_REF_SVH
`define TB_FPU_REF_SVH

// Canonical quiet NaN, right aligned in the register
function automatic logic [31:0] ref_canon_nan(input fp_format_e fmt);
  return (fmt == FP16) ? 32'h0000_7e00 : 32'h7fc0_0000;
endfunction

// Operand value as the slice must see it, FP16 needs a full box of ones
function automatic logic [31:0] ref_operand(input fp_format_e fmt, input logic [31:0] raw);
  if (fmt == FP32) begin
    return raw;
  end
  return (raw[31:16] == 16'hffff) ? {16'h0, raw[15:0]} : ref_canon_nan(fmt);
endfunction

function automatic int ref_sign_pos(input fp_format_e fmt);
  return (fmt == FP16) ? 15 : 31;
endfunction

// One-hot mask in RISC-V order, mantissa widened to 23 bits
function automatic logic [9:0] ref_class(input fp_format_e fmt, input logic [31:0] v);
  logic        sgn;
  logic        e_zero;
  logic        e_ones;
  logic [22:0] m;
  sgn    = v[ref_sign_pos(fmt)];
  e_zero = (fmt == FP16) ? (v[14:10] == 5'h00) : (v[30:23] == 8'h00);
  e_ones = (fmt == FP16) ? (v[14:10] == 5'h1f) : (v[30:23] == 8'hff);
  m      = (fmt == FP16) ? {v[9:0], 13'h0} : v[22:0];
  if (e_ones && m != 0)
    return m[22] ? 10'h200 : 10'h100;
  if (e_ones)
    return sgn ? 10'h001 : 10'h080;
  if (e_zero && m == 0)
    return sgn ? 10'h008 : 10'h010;
  if (e_zero)
    return sgn ? 10'h004 : 10'h020;
  return sgn ? 10'h002 : 10'h040;
endfunction

// Signed magnitude as an integer, both zeros map to 0
function automatic longint ref_key(input fp_format_e fmt, input logic [31:0] v);
  longint mag;
  mag = (fmt == FP16) ? longint'(v[14:0]) : longint'(v[30:0]);
  return v[ref_sign_pos(fmt)] ? -mag : mag;
endfunction

function automatic fpu_rsp_t ref_response(input fpu_req_t req);
  fp_format_e  fmt;
  logic [31:0] a, b, res;
  logic [9:0]  ca, cb;
  logic        nan_a, nan_b, take_a, nv;
  int          sp;
  longint      ka, kb;
  fmt   = req.dst_fmt;
  a     = ref_operand(fmt, req.operand_a);
  b     = ref_operand(fmt, req.operand_b);
  ca    = ref_class(fmt, a);
  cb    = ref_class(fmt, b);
  nan_a = |ca[9:8];
  nan_b = |cb[9:8];
  sp    = ref_sign_pos(fmt);
  ka    = ref_key(fmt, a);
  kb    = ref_key(fmt, b);
  res   = a;
  nv    = 1'b0;
  case (req.op)
    MIN, MAX: begin
      nv     = ca[8] | cb[8];
      // Equal keys differ only for zeros, min takes the negative one
      take_a = (ka == kb) ? (a[sp] == (req.op == MIN)) : ((ka < kb) == (req.op == MIN));
      if (nan_a && nan_b)
        res = ref_canon_nan(fmt);
      else if (nan_a || nan_b)
        res = nan_a ? b : a;
      else
        res = take_a ? a : b;
    end
    FEQ: begin
      nv  = ca[8] | cb[8];
      res = 32'(!nan_a && !nan_b && ka == kb);
    end
    FLT: begin
      nv  = nan_a | nan_b;
      res = 32'(!nv && ka < kb);
    end
    FLE: begin
      nv  = nan_a | nan_b;
      res = 32'(!nv && ka <= kb);
    end
    SGNJ:  res[sp] = b[sp];
    SGNJN: res[sp] = ~b[sp];
    SGNJX: res[sp] = a[sp] ^ b[sp];
    CLASS: res = 32'(ca);
    default: ;
  endcase
  // FP16 values go back boxed, integer results do not
  if (fmt == FP16 && !(req.op inside {FEQ, FLT, FLE, CLASS}))
    res = {16'hffff, res[15:0]};
  return '{result: res, status: '{nv: nv}, tag: req.tag};
endfunction

`endif

// ==== tb_fpu_noncomp.sv ====
module tb_fpu_noncomp
  import fpu_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  `include "tb_fpu_ref.svh"

  localparam int NUM_PAIRS   = 8;
  localparam int NUM_OPS     = 9;
  localparam int NUM_RAND    = 300;
  localparam int TOTAL_REQS  = 2 * NUM_PAIRS * NUM_OPS + 2 * NUM_OPS + 2 + NUM_RAND;
  localparam int CYCLE_LIMIT = 4 * TOTAL_REQS + 200;

  // Directed operands +0, -0, 1, 2, -1, qNaN, sNaN, +inf, smallest subnormal
  localparam logic [31:0] DIR32 [9] = '{32'h0000_0000, 32'h8000_0000, 32'h3f80_0000,
    32'h4000_0000, 32'hbf80_0000, 32'h7fc0_0000, 32'h7f80_0001, 32'h7f80_0000, 32'h0000_0001};
  localparam logic [15:0] DIR16 [9] = '{16'h0000, 16'h8000, 16'h3c00, 16'h4000, 16'hbc00,
    16'h7e00, 16'h7c01, 16'h7c00, 16'h0001};
  localparam int PAIR_A [NUM_PAIRS] = '{0, 1, 5, 2, 5, 4, 2, 8};
  localparam int PAIR_B [NUM_PAIRS] = '{1, 0, 2, 6, 6, 3, 2, 7};

  logic       clk_i, arst_n_i, flush_i, busy_o;
  logic       in_valid_i, in_ready_o, out_valid_o, out_ready_i;
  fpu_req_t   req_i;
  fpu_rsp_t   rsp_o;
  logic       in_hs, out_hs;
  integer     seed;
  logic       bp_en;
  tag_t       next_tag;
  int         err_cnt, rsp_cnt, req_cnt, cycle_cnt;

  // Scoreboard, one queue per format
  fpu_rsp_t   exp_q [NUM_FORMATS][$];
  fpu_rsp_t   exp_head [NUM_FORMATS];
  int         pend_cnt [NUM_FORMATS];
  int         total_pending;
  fp_format_e tag_fmt [2**TAG_WIDTH];
  fp_format_e cur_fmt;
  fpu_rsp_t   cur_exp;
  logic       cur_pend, dst_empty;

  assign in_hs     = in_valid_i & in_ready_o;
  assign out_hs    = out_valid_o & out_ready_i;
  assign cur_fmt   = tag_fmt[rsp_o.tag];
  assign cur_exp   = exp_head[cur_fmt];
  assign cur_pend  = pend_cnt[cur_fmt] != 0;
  assign dst_empty = pend_cnt[req_i.dst_fmt] == 0;

  fpu_noncomp_top fpu_noncomp_top_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i or negedge arst_n_i) begin : scoreboard
    fp_format_e f;
    if (!arst_n_i || flush_i) begin
      for (int i = 0; i < NUM_FORMATS; i++) begin
        exp_q[i].delete();
      end
    end else begin
      if (out_hs) begin
        f = tag_fmt[rsp_o.tag];
        if (exp_q[f].size() != 0) begin
          void'(exp_q[f].pop_front());
        end
        rsp_cnt++;
      end
      if (in_hs) begin
        exp_q[req_i.dst_fmt].push_back(ref_response(req_i));
        tag_fmt[req_i.tag] = req_i.dst_fmt;
      end
    end
    total_pending = 0;
    for (int i = 0; i < NUM_FORMATS; i++) begin
      pend_cnt[i]    = exp_q[i].size();
      exp_head[i]    = (pend_cnt[i] != 0) ? exp_q[i][0] : '0;
      total_pending += pend_cnt[i];
    end
  end

  // ----------------------------------------
  // Response checks
  // ----------------------------------------
  rsp_known: assert property (@(posedge clk_i) disable iff (!arst_n_i) out_hs |-> cur_pend)
    else begin
      err_cnt++;
      $display("Response with tag %h arrived while nothing was pending", $sampled(rsp_o.tag));
    end

  rsp_result: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_hs && cur_pend |-> rsp_o.result == cur_exp.result)
    else begin
      err_cnt++;
      $display("** Error rsp_o.result: expected %h, actual %h",
               $sampled(cur_exp.result), $sampled(rsp_o.result));
    end

  rsp_nv: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_hs && cur_pend |-> rsp_o.status.nv == cur_exp.status.nv)
    else begin
      err_cnt++;
      $display("** Error rsp_o.status.nv: expected %h, actual %h",
               $sampled(cur_exp.status.nv), $sampled(rsp_o.status.nv));
    end

  // Head tag catches reordering within a format
  rsp_order: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_hs && cur_pend |-> rsp_o.tag == cur_exp.tag)
    else begin
      err_cnt++;
      $display("** Error rsp_o.tag: expected %h, actual %h",
               $sampled(cur_exp.tag), $sampled(rsp_o.tag));
    end

  rsp_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_o && !out_ready_i && !flush_i |=> out_valid_o && $stable(rsp_o))
    else begin
      err_cnt++;
      $display("Stalled response changed or vanished before it was taken");
    end

  one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    in_hs && !flush_i && (total_pending == 0 || (total_pending == 1 && out_hs))
    |=> out_valid_o && rsp_o.tag == $past(req_i.tag))
    else begin
      err_cnt++;
      $display("Accepted request did not show up on the output one cycle later");
    end

  free_slice: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    in_valid_i && dst_empty |-> in_ready_o)
    else begin
      err_cnt++;
      $display("Request stalled although its slice was empty");
    end

  flush_clear: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    flush_i |=> !out_valid_o && !busy_o)
    else begin
      err_cnt++;
      $display("Items still visible one cycle after flush");
    end

  busy_match: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    busy_o == (total_pending != 0))
    else begin
      err_cnt++;
      $display("Busy flag disagrees with the number of pending responses");
    end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  task automatic tick();
    @(posedge clk_i);
    if (bp_en) begin
      out_ready_i <= 1'($random(seed));
    end
  endtask

  task automatic issue(input logic [31:0] a, input logic [31:0] b, input operation_e op,
                       input fp_format_e fmt);
    req_i      <= '{operand_a: a, operand_b: b, op: op, dst_fmt: fmt, tag: next_tag};
    in_valid_i <= 1'b1;
    next_tag++;
    req_cnt++;
    tick();
    while (!in_ready_o) begin
      tick();
    end
    in_valid_i <= 1'b0;
  endtask

  // Weighted toward zeros, infinities, NaNs and subnormals
  function automatic logic [31:0] rand_operand(input fp_format_e fmt);
    logic [31:0] r;
    logic [31:0] v;
    logic [15:0] h;
    r = $random(seed);
    v = $random(seed);
    case (r[2:0])
      3'd0: v = {r[3], 31'h0};
      3'd1: v = {r[3], 8'hff, 23'h0};
      3'd2: v = {r[3], 8'hff, 1'b1, v[21:0]};
      3'd3: v = {r[3], 8'hff, 2'b01, v[20:0]};
      3'd4: v = {r[3], 8'h00, v[22:1], 1'b1};
      default: ;
    endcase
    if (fmt == FP32)
      return v;
    case (r[2:0])
      3'd0: h = {r[3], 15'h0};
      3'd1: h = {r[3], 5'h1f, 10'h0};
      3'd2: h = {r[3], 5'h1f, 1'b1, v[8:0]};
      3'd3: h = {r[3], 5'h1f, 2'b01, v[7:0]};
      3'd4: h = {r[3], 5'h00, v[9:1], 1'b1};
      default: h = v[15:0];
    endcase
    // Now and then an upper half that is not all ones
    return (r[7:4] == 4'h0) ? {r[31:17], 1'b0, h} : {16'hffff, h};
  endfunction

  always @(posedge clk_i) begin : watchdog
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: run still going after %0d cycles", CYCLE_LIMIT);
      $display("Summary: %0d requests, %0d responses, %0d errors, 1 timeout",
               req_cnt, rsp_cnt, err_cnt);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    fp_format_e  fmt;
    operation_e  op;
    logic [31:0] a;
    logic [31:0] b;
    seed        = 32'h7c32_3c9f;
    arst_n_i    = 1'b0;
    req_i       = '0;
    in_valid_i  = 1'b0;
    flush_i     = 1'b0;
    out_ready_i = 1'b1;
    bp_en       = 1'b0;
    next_tag    = '0;
    err_cnt     = 0;
    rsp_cnt     = 0;
    req_cnt     = 0;
    cycle_cnt   = 0;
    repeat (16) @(posedge clk_i);
    arst_n_i <= 1'b1;
    reset_idle: assert (!out_valid_o && !busy_o)
      else begin
        err_cnt++;
        $display("Outputs not idle after reset");
      end
    tick();
    // Formats alternate so requests go back to back
    for (int p = 0; p < NUM_PAIRS; p++) begin
      for (int o = 0; o < NUM_OPS; o++) begin
        issue(DIR32[PAIR_A[p]], DIR32[PAIR_B[p]], operation_e'(o), FP32);
        issue({16'hffff, DIR16[PAIR_A[p]]}, {16'hffff, DIR16[PAIR_B[p]]}, operation_e'(o), FP16);
      end
    end
    for (int o = 0; o < NUM_OPS; o++) begin
      issue(32'h0000_3c00, 32'hffff_4000, operation_e'(o), FP16);
      issue(32'hffff_4000, 32'h7fff_3c00, operation_e'(o), FP16);
    end
    // Flush with one item held in each slice
    issue(DIR32[2], DIR32[3], MAX, FP32);
    out_ready_i <= 1'b0;
    issue({16'hffff, DIR16[4]}, {16'hffff, DIR16[0]}, MIN, FP16);
    flush_i <= 1'b1;
    tick();
    flush_i <= 1'b0;
    bp_en = 1'b1;
    for (int i = 0; i < NUM_RAND; i++) begin
      fmt = fp_format_e'($random(seed));
      op  = operation_e'({$random(seed)} % NUM_OPS);
      a   = rand_operand(fmt);
      b   = rand_operand(fmt);
      issue(a, b, op, fmt);
    end
    bp_en = 1'b0;
    out_ready_i <= 1'b1;
    @(negedge clk_i);
    while (total_pending != 0) begin
      @(negedge clk_i);
    end
    repeat (2) tick();
    $display("Summary: %0d requests, %0d responses, %0d errors, 0 timeouts",
             req_cnt, rsp_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== fpu_noncomp_top.sv ====
module fpu_noncomp_top
  import fpu_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  // Request side
  input  fpu_req_t req_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  logic     flush_i,
  // Response side
  output fpu_rsp_t rsp_o,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  // High while any slice holds an item
  output logic     busy_o
);

  fpu_opgroup_block i_noncomp_block (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .req_i       ( req_i       ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .flush_i     ( flush_i     ),
    .rsp_o       ( rsp_o       ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .busy_o      ( busy_o      )
  );

endmodule

// ==== fpu_opgroup_block.sv ====
module fpu_opgroup_block
  import fpu_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  fpu_req_t req_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  logic     flush_i,
  output fpu_rsp_t rsp_o,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output logic     busy_o
);

  logic [NUM_FORMATS-1:0]     fmt_in_ready;
  logic [NUM_FORMATS-1:0]     fmt_out_valid;
  logic [NUM_FORMATS-1:0]     fmt_out_ready;
  logic [NUM_FORMATS-1:0]     fmt_busy;
  fpu_rsp_t [NUM_FORMATS-1:0] fmt_rsp;

  // ----------------------------------------
  // Input steering
  // ----------------------------------------
  // Only the destination slice decides readiness
  assign in_ready_o = fmt_in_ready[req_i.dst_fmt];

  for (genvar fmt = 0; fmt < NUM_FORMATS; fmt++) begin : gen_parallel_slices
    logic in_valid;

    assign in_valid = in_valid_i & (req_i.dst_fmt == fp_format_e'(fmt));

    fpu_noncomp_fmt_slice #(
      .FpFormat ( fp_format_e'(fmt) )
    ) i_fmt_slice (
      .clk_i       ( clk_i              ),
      .arst_n_i    ( arst_n_i           ),
      .req_i       ( req_i              ),
      .in_valid_i  ( in_valid           ),
      .in_ready_o  ( fmt_in_ready[fmt]  ),
      .flush_i     ( flush_i            ),
      .rsp_o       ( fmt_rsp[fmt]       ),
      .out_valid_o ( fmt_out_valid[fmt] ),
      .out_ready_i ( fmt_out_ready[fmt] ),
      .busy_o      ( fmt_busy[fmt]      )
    );
  end

  // ----------------------------------------
  // Output arbitration
  // ----------------------------------------
  fpu_rr_arbiter i_arbiter (
    .clk_i       ( clk_i         ),
    .arst_n_i    ( arst_n_i      ),
    .flush_i     ( flush_i       ),
    .req_valid_i ( fmt_out_valid ),
    .req_ready_o ( fmt_out_ready ),
    .req_rsp_i   ( fmt_rsp       ),
    .out_valid_o ( out_valid_o   ),
    .out_ready_i ( out_ready_i   ),
    .rsp_o       ( rsp_o         )
  );

  assign busy_o = |fmt_busy;

endmodule

// ==== fpu_rr_arbiter.sv ====
module fpu_rr_arbiter
  import fpu_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       flush_i,
  input  logic [NUM_FORMATS-1:0]     req_valid_i,
  output logic [NUM_FORMATS-1:0]     req_ready_o,
  input  fpu_rsp_t [NUM_FORMATS-1:0] req_rsp_i,
  output logic                       out_valid_o,
  input  logic                       out_ready_i,
  output fpu_rsp_t                   rsp_o
);

  fp_format_e rr_q;
  fp_format_e lock_idx_q;
  logic       lock_q;
  fp_format_e rr_pick;
  fp_format_e grant;

  // ----------------------------------------
  // Round-robin search
  // ----------------------------------------
  // First valid input at or after the pointer
  always_comb begin : rr_search
    int unsigned cand;
    logic        found;
    rr_pick = rr_q;
    found   = 1'b0;
    for (int unsigned i = 0; i < NUM_FORMATS; i++) begin
      cand = (rr_q + i) % NUM_FORMATS;
      if (!found && req_valid_i[cand]) begin
        rr_pick = fp_format_e'(cand);
        found   = 1'b1;
      end
    end
  end

  // A stalled output keeps its winner until it is taken
  assign grant       = lock_q ? lock_idx_q : rr_pick;
  assign out_valid_o = req_valid_i[grant];
  assign rsp_o       = req_rsp_i[grant];

  always_comb begin : ready_demux
    req_ready_o        = '0;
    req_ready_o[grant] = out_ready_i;
  end

  // ----------------------------------------
  // Pointer and lock state
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q       <= FP32;
      lock_q     <= 1'b0;
      lock_idx_q <= FP32;
    end else if (flush_i) begin
      rr_q   <= FP32;
      lock_q <= 1'b0;
    end else begin
      lock_q     <= out_valid_o & ~out_ready_i;
      lock_idx_q <= grant;
      // Next search starts one past the winner
      if (out_valid_o && out_ready_i) begin
        rr_q <= fp_format_e'((grant + 1) % NUM_FORMATS);
      end
    end
  end

endmodule

// ==== fpu_noncomp_fmt_slice.sv ====
module fpu_noncomp_fmt_slice
  import fpu_pkg::*;
#(
  parameter fp_format_e FpFormat = FP32
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  fpu_req_t req_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  logic     flush_i,
  output fpu_rsp_t rsp_o,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output logic     busy_o
);

  localparam int unsigned EXP_BITS = exp_bits(FpFormat);
  localparam int unsigned MAN_BITS = man_bits(FpFormat);
  localparam int unsigned FP_W     = 1 + EXP_BITS + MAN_BITS;

  // Positive quiet NaN with only the top mantissa bit set
  localparam logic [FP_W-1:0] CANON_NAN = {1'b0, {EXP_BITS{1'b1}}, 1'b1, {(MAN_BITS-1){1'b0}}};

  typedef struct packed {
    logic sign;
    logic is_zero;
    logic is_subnormal;
    logic is_normal;
    logic is_inf;
    logic is_snan;
    logic is_qnan;
  } fp_info_t;

  function automatic fp_info_t classify(input logic [FP_W-1:0] v);
    logic [EXP_BITS-1:0] exp_f;
    logic [MAN_BITS-1:0] man_f;
    fp_info_t            info;
    exp_f             = v[FP_W-2 -: EXP_BITS];
    man_f             = v[MAN_BITS-1:0];
    info.sign         = v[FP_W-1];
    info.is_zero      = (exp_f == '0) && (man_f == '0);
    info.is_subnormal = (exp_f == '0) && (man_f != '0);
    info.is_normal    = (exp_f != '0) && (exp_f != '1);
    info.is_inf       = (exp_f == '1) && (man_f == '0);
    info.is_snan      = (exp_f == '1) && (man_f != '0) && !man_f[MAN_BITS-1];
    info.is_qnan      = (exp_f == '1) && man_f[MAN_BITS-1];
    return info;
  endfunction

  logic [FP_W-1:0]        val_a, val_b;
  logic [FP_W-2:0]        mag_a, mag_b;
  logic [FP_W-1:0]        fp_res;
  logic [WIDTH-1:0]       fp_res_boxed;
  logic [WIDTH-1:0]       int_res;
  logic                   int_res_sel;
  logic                   nv;
  fp_info_t               info_a, info_b;
  logic                   a_nan, b_nan, any_nan, any_snan, both_zero;
  logic                   ord_lt, ieee_eq, ieee_lt;
  logic [CLASS_WIDTH-1:0] class_mask;
  fpu_rsp_t               rsp_d, rsp_q;
  logic                   out_valid_q;

  // ----------------------------------------
  // Operand unpacking and result boxing
  // ----------------------------------------
  if (FP_W < WIDTH) begin : gen_nan_box
    // Operands without a full box of ones read as canonical NaN
    assign val_a = (&req_i.operand_a[WIDTH-1:FP_W]) ? req_i.operand_a[FP_W-1:0] : CANON_NAN;
    assign val_b = (&req_i.operand_b[WIDTH-1:FP_W]) ? req_i.operand_b[FP_W-1:0] : CANON_NAN;
    assign fp_res_boxed = {{(WIDTH-FP_W){1'b1}}, fp_res};
  end else begin : gen_full_width
    assign val_a        = req_i.operand_a;
    assign val_b        = req_i.operand_b;
    assign fp_res_boxed = fp_res;
  end

  assign mag_a  = val_a[FP_W-2:0];
  assign mag_b  = val_b[FP_W-2:0];
  assign info_a = classify(val_a);
  assign info_b = classify(val_b);

  assign a_nan     = info_a.is_snan | info_a.is_qnan;
  assign b_nan     = info_b.is_snan | info_b.is_qnan;
  assign any_nan   = a_nan | b_nan;
  assign any_snan  = info_a.is_snan | info_b.is_snan;
  assign both_zero = info_a.is_zero & info_b.is_zero;

  // Total order on sign and magnitude, so -0 sorts below +0
  always_comb begin : ord_cmp
    if (info_a.sign != info_b.sign) begin
      ord_lt = info_a.sign;
    end else if (info_a.sign) begin
      ord_lt = mag_a > mag_b;
    end else begin
      ord_lt = mag_a < mag_b;
    end
  end

  // IEEE compares treat both zeros as equal
  assign ieee_eq = (val_a == val_b) | both_zero;
  assign ieee_lt = ord_lt & ~both_zero;

  always_comb begin : class_enc
    class_mask = '0;
    if (info_a.is_snan) begin
      class_mask[CLASS_SNAN] = 1'b1;
    end else if (info_a.is_qnan) begin
      class_mask[CLASS_QNAN] = 1'b1;
    end else if (info_a.is_inf) begin
      class_mask[info_a.sign ? CLASS_NEG_INF : CLASS_POS_INF] = 1'b1;
    end else if (info_a.is_normal) begin
      class_mask[info_a.sign ? CLASS_NEG_NRM : CLASS_POS_NRM] = 1'b1;
    end else if (info_a.is_subnormal) begin
      class_mask[info_a.sign ? CLASS_NEG_SUB : CLASS_POS_SUB] = 1'b1;
    end else begin
      class_mask[info_a.sign ? CLASS_NEG_ZER : CLASS_POS_ZER] = 1'b1;
    end
  end

  // ----------------------------------------
  // Operation select
  // ----------------------------------------
  always_comb begin : op_sel
    fp_res      = CANON_NAN;
    int_res     = '0;
    int_res_sel = 1'b0;
    nv          = 1'b0;
    case (req_i.op)
      MIN, MAX: begin
        nv = any_snan;
        if (a_nan && b_nan) begin
          fp_res = CANON_NAN;
        end else if (a_nan) begin
          fp_res = val_b;
        end else if (b_nan) begin
          fp_res = val_a;
        end else if (req_i.op == MIN) begin
          fp_res = ord_lt ? val_a : val_b;
        end else begin
          fp_res = ord_lt ? val_b : val_a;
        end
      end
      FEQ: begin
        int_res_sel = 1'b1;
        nv          = any_snan;
        int_res[0]  = ~any_nan & ieee_eq;
      end
      FLT: begin
        int_res_sel = 1'b1;
        nv          = any_nan;
        int_res[0]  = ~any_nan & ieee_lt;
      end
      FLE: begin
        int_res_sel = 1'b1;
        nv          = any_nan;
        int_res[0]  = ~any_nan & (ieee_lt | ieee_eq);
      end
      SGNJ:  fp_res = {info_b.sign, mag_a};
      SGNJN: fp_res = {~info_b.sign, mag_a};
      SGNJX: fp_res = {info_a.sign ^ info_b.sign, mag_a};
      CLASS: begin
        int_res_sel = 1'b1;
        int_res     = WIDTH'(class_mask);
      end
      default: ;
    endcase
  end

  assign rsp_d.result    = int_res_sel ? int_res : fp_res_boxed;
  assign rsp_d.status.nv = nv;
  assign rsp_d.tag       = req_i.tag;

  // ----------------------------------------
  // Output register
  // ----------------------------------------
  // Accepts while empty or while the held item drains this cycle
  assign in_ready_o = ~out_valid_q | out_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_valid_q <= 1'b0;
    end else if (flush_i) begin
      out_valid_q <= 1'b0;
    end else if (in_ready_o) begin
      out_valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_o       = rsp_q;
  assign out_valid_o = out_valid_q;
  assign busy_o      = out_valid_q;

endmodule

// ==== fpu_pkg.sv ====
package fpu_pkg;

  // ----------------------------------------
  // Global widths
  // ----------------------------------------
  localparam int unsigned WIDTH       = 32;
  localparam int unsigned NUM_FORMATS = 2;
  localparam int unsigned TAG_WIDTH   = 4;

  // Exponent and mantissa widths per format
  localparam int unsigned FP32_EXP = 8;
  localparam int unsigned FP32_MAN = 23;
  localparam int unsigned FP16_EXP = 5;
  localparam int unsigned FP16_MAN = 10;

  // ----------------------------------------
  // Classify mask bit positions
  // ----------------------------------------
  localparam int unsigned CLASS_WIDTH   = 10;
  localparam int unsigned CLASS_NEG_INF = 0;
  localparam int unsigned CLASS_NEG_NRM = 1;
  localparam int unsigned CLASS_NEG_SUB = 2;
  localparam int unsigned CLASS_NEG_ZER = 3;
  localparam int unsigned CLASS_POS_ZER = 4;
  localparam int unsigned CLASS_POS_SUB = 5;
  localparam int unsigned CLASS_POS_NRM = 6;
  localparam int unsigned CLASS_POS_INF = 7;
  localparam int unsigned CLASS_SNAN    = 8;
  localparam int unsigned CLASS_QNAN    = 9;

  // ----------------------------------------
  // Enumerations
  // ----------------------------------------
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  typedef enum logic [3:0] {
    MIN   = 4'd0,
    MAX   = 4'd1,
    FEQ   = 4'd2,
    FLT   = 4'd3,
    FLE   = 4'd4,
    SGNJ  = 4'd5,
    SGNJN = 4'd6,
    SGNJX = 4'd7,
    CLASS = 4'd8
  } operation_e;

  // ----------------------------------------
  // Request and response types
  // ----------------------------------------
  typedef struct packed {
    logic nv;
  } status_t;

  typedef logic [TAG_WIDTH-1:0] tag_t;

  typedef struct packed {
    logic [WIDTH-1:0] operand_a;
    logic [WIDTH-1:0] operand_b;
    operation_e       op;
    fp_format_e       dst_fmt;
    tag_t             tag;
  } fpu_req_t;

  typedef struct packed {
    logic [WIDTH-1:0] result;
    status_t          status;
    tag_t             tag;
  } fpu_rsp_t;

  // ----------------------------------------
  // Format helpers
  // ----------------------------------------
  function automatic int unsigned exp_bits(input fp_format_e fmt);
    if (fmt == FP16) begin
      return FP16_EXP;
    end
    return FP32_EXP;
  endfunction

  function automatic int unsigned man_bits(input fp_format_e fmt);
    if (fmt == FP16) begin
      return FP16_MAN;
    end
    return FP32_MAN;
  endfunction

endpackage
